// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// cache geometry, 16 bit word addressed space
	localparam int tag_w           = 5;	// addr[15:11]
	localparam int index_w         = 7;	// addr[10:4], one block per set
	localparam int offset_w        = 3;	// addr[3:1], word within block
	localparam int num_blocks      = 128;	// 2**index_w
	localparam int words_per_block = 8;	// 2**offset_w
	localparam int data_w          = 16;	// word width, also the memory bus width

	// byte address as seen by the requester
	// zero is addr[0], words are always 2 byte aligned
	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;
		logic                zero;
	} cache_addr_t;

	// one metadata entry per block
	typedef struct packed {
		logic             valid;	// block holds real data
		logic [tag_w-1:0] tag;		// tag of the resident block
	} meta_t;

	// fill controller states
	typedef enum logic [1:0] {
		st_idle,	// serving hits, watching for a miss
		st_fill,	// requesting and collecting the 8 block words
		st_commit	// all words in, write valid + tag
	} fill_state_t;

endpackage

`default_nettype wire

// ==== rtl/data_array.sv ====
`default_nettype none

// block data storage, 128 blocks x 8 words
module data_array import cache_pkg::*; (
	input  logic              clk,
	input  cache_addr_t       addr,		// index picks block, offset picks word
	input  logic              wr_en,
	input  logic [data_w-1:0] wr_data,	// from mem_data, fill word or write data
	output logic [data_w-1:0] rd_data
);

	logic [data_w-1:0] word_q [num_blocks][words_per_block];	// no reset, valid bits guard it

	logic [num_blocks-1:0]      block_en;	// one-hot from index
	logic [words_per_block-1:0] word_en;	// one-hot from offset

	assign block_en = num_blocks'(1) << addr.index;
	assign word_en  = words_per_block'(1) << addr.offset;

	// synchronous write, only the word with both enables set takes data
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < num_blocks; b++) begin
				for (int w = 0; w < words_per_block; w++) begin
					if (block_en[b] && word_en[w]) begin
						word_q[b][w] <= wr_data;
					end
				end
			end
		end
	end

	// asynchronous read, a hit returns data in the same cycle
	assign rd_data = word_q[addr.index][addr.offset];

endmodule

`default_nettype wire

// ==== rtl/meta_data_array.sv ====
`default_nettype none

// valid + tag storage and the hit compare
module meta_data_array import cache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  cache_addr_t addr,	// index selects entry, tag is compared
	input  logic        wr_en,	// write meta_in at addr.index
	input  meta_t       meta_in,
	output logic        hit
);

	meta_t entry_q [num_blocks];	// one entry per block

	logic [num_blocks-1:0] block_en;	// one-hot index decode
	meta_t                 entry;	// entry at addr.index

	assign block_en = num_blocks'(1) << addr.index;

	// valid bits clear on reset so every block starts as a miss
	// tags keep whatever they hold, a clear valid bit makes them don't care
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_blocks; i++) begin
				entry_q[i].valid <= 1'b0;
			end
		end else if (wr_en) begin
			for (int i = 0; i < num_blocks; i++) begin
				if (block_en[i]) begin
					entry_q[i] <= meta_in;
				end
			end
		end
	end

	// lookup, purely combinational
	assign entry = entry_q[addr.index];
	assign hit   = entry.valid & (entry.tag == addr.tag);	// valid and same block

endmodule

`default_nettype wire

// ==== rtl/cache_fill_fsm.sv ====
`default_nettype none

// miss handling and write-through control
module cache_fill_fsm import cache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        read_req,		// requester wants a word
	input  logic        wrt_cmd,		// requester wants to write a word
	input  logic        hit,			// valid and tag match at array_addr
	input  logic        mem_data_valid,	// memory is returning a fill word
	input  cache_addr_t addr_in,		// requester address
	output logic        fsm_busy,		// stall, high while a fill is underway
	output logic        mem_rd,		// fill read strobe to memory
	output logic        wrt_mem,		// write-through strobe to memory
	output cache_addr_t miss_addr,		// memory address for mem_rd / wrt_mem
	output cache_addr_t array_addr,		// address presented to both arrays
	output logic        wr_data_en,		// data array write
	output logic        wr_meta_en,		// meta array write
	output meta_t       meta_in		// entry written on commit
);

	localparam logic [offset_w-1:0] last_off = offset_w'(words_per_block - 1);

	fill_state_t state_q;
	fill_state_t state_d;

	logic [offset_w-1:0] issue_cnt_q;	// offset of the next read to issue
	logic [offset_w-1:0] rcv_cnt_q;	// offset of the next word to come back
	logic                issue_done_q;	// all 8 reads are out
	logic [tag_w-1:0]    fill_tag_q;	// block being filled
	logic [index_w-1:0]  fill_index_q;

	logic cmd;
	logic miss;
	logic wrt_hit;
	logic fill_word;
	logic last_word;

	assign cmd       = read_req | wrt_cmd;
	assign miss      = (state_q == st_idle) & cmd & ~hit;	// start a fill
	assign wrt_hit   = (state_q == st_idle) & wrt_cmd & hit;	// write-through case
	assign fill_word = (state_q == st_fill) & mem_data_valid;
	assign last_word = fill_word & (rcv_cnt_q == last_off);	// eighth word arriving

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (miss) begin
					state_d = st_fill;
				end
			end
			st_fill: begin
				// only the returning words move us on, read issue is free running
				if (last_word) begin
					state_d = st_commit;
				end
			end
			st_commit: begin
				state_d = st_idle;	// one cycle for the meta write
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	// state and counters
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= st_idle;
			issue_cnt_q  <= '0;
			rcv_cnt_q    <= '0;
			issue_done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (miss) begin
				issue_cnt_q  <= '0;	// fill always starts at offset 0
				rcv_cnt_q    <= '0;
				issue_done_q <= 1'b0;
			end else begin
				if (mem_rd) begin
					issue_cnt_q <= issue_cnt_q + 1'b1;	// wraps back to 0 after 7
					if (issue_cnt_q == last_off) begin
						issue_done_q <= 1'b1;
					end
				end
				if (fill_word) begin
					rcv_cnt_q <= rcv_cnt_q + 1'b1;
				end
			end
		end
	end

	// block under fill, captured from the missing request
	always_ff @(posedge clk) begin
		if (miss) begin
			fill_tag_q   <= addr_in.tag;
			fill_index_q <= addr_in.index;
		end
	end

	// memory side
	assign fsm_busy = (state_q != st_idle);
	assign mem_rd   = (state_q == st_fill) & ~issue_done_q;
	assign wrt_mem  = wrt_hit;

	always_comb begin
		if (state_q == st_idle) begin
			miss_addr = addr_in;	// write-through goes straight to memory
		end else begin
			miss_addr = '{tag: fill_tag_q, index: fill_index_q, offset: issue_cnt_q, zero: 1'b0};
		end
	end

	// array side
	always_comb begin
		case (state_q)
			st_fill:   array_addr = '{tag: fill_tag_q, index: fill_index_q,
						offset: rcv_cnt_q, zero: 1'b0};	// word being received
			st_commit: array_addr = '{tag: fill_tag_q, index: fill_index_q,
						offset: '0, zero: 1'b0};
			default:   array_addr = addr_in;
		endcase
	end

	assign wr_data_en = wrt_hit | fill_word;	// write hit data or fill word, both on mem_data
	assign wr_meta_en = (state_q == st_commit);
	assign meta_in    = '{valid: 1'b1, tag: fill_tag_q};	// only entry ever written

endmodule

`default_nettype wire

// ==== rtl/cache.sv ====
`default_nettype none

// direct mapped, write-through, write-allocate cache
module cache import cache_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              read_req,		// held until hit & ~fsm_busy
	input  logic              wrt_cmd,		// held until hit & ~fsm_busy
	input  cache_addr_t       addr_in,
	input  logic [data_w-1:0] mem_data,		// write data in, fill words back from memory
	input  logic              mem_data_valid,	// fill word present on mem_data
	output logic              hit,
	output logic              fsm_busy,		// requester stall
	output logic              mem_rd,		// fill read to memory
	output logic              wrt_mem,		// write-through to memory
	output cache_addr_t       miss_addr,		// address for mem_rd and wrt_mem
	output logic [data_w-1:0] data_out
);

	cache_addr_t array_addr;	// addr_in when idle, fill address otherwise
	logic        wr_data_en;
	logic        wr_meta_en;
	meta_t       meta_in;

	// control
	cache_fill_fsm fsm_i (
		.clk            (clk),
		.rst            (rst),
		.read_req       (read_req),
		.wrt_cmd        (wrt_cmd),
		.hit            (hit),
		.mem_data_valid (mem_data_valid),
		.addr_in        (addr_in),
		.fsm_busy       (fsm_busy),
		.mem_rd         (mem_rd),
		.wrt_mem        (wrt_mem),
		.miss_addr      (miss_addr),
		.array_addr     (array_addr),
		.wr_data_en     (wr_data_en),
		.wr_meta_en     (wr_meta_en),
		.meta_in        (meta_in)
	);

	// valid + tag, produces hit
	meta_data_array meta_i (
		.clk     (clk),
		.rst     (rst),
		.addr    (array_addr),
		.wr_en   (wr_meta_en),
		.meta_in (meta_in),
		.hit     (hit)
	);

	// words, written straight from the shared bus
	data_array data_i (
		.clk     (clk),
		.addr    (array_addr),
		.wr_en   (wr_data_en),
		.wr_data (mem_data),
		.rd_data (data_out)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

// free running testbench clock, period 10
module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;	// 5 low, 5 high

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
`default_nettype none

// main memory stand-in for the cache
// reads are pipelined, one new read per cycle, data back after latency cycles
module mem_model import cache_pkg::*; #(
	parameter int latency = 4	// cycles from mem_rd to mem_data_valid
) (
	input  logic              clk,
	input  logic              mem_rd,	// fill read strobe
	input  logic              wrt_mem,	// write-through strobe
	input  logic [15:0]       addr,		// miss_addr from the cache
	input  logic [data_w-1:0] wdata,	// shared bus, requester data on a write
	output logic [data_w-1:0] rdata,
	output logic              rvalid
);

	logic [data_w-1:0] mem [65536];	// indexed by byte address, odd entries unused

	logic        vld_q  [latency];	// read pipeline, stage 0 is the newest
	logic [15:0] addr_q [latency];

	// initial content, a mix of the whole address
	function automatic logic [data_w-1:0] preload(input logic [15:0] a);
		return (a ^ 16'h3c5a) + {a[7:0], a[15:8]};
	endfunction

	initial begin
		for (int i = 0; i < 65536; i++) begin
			mem[i] = preload(16'(i));
		end
		for (int s = 0; s < latency; s++) begin
			vld_q[s] = 1'b0;	// nothing in flight at start
		end
	end

	always @(posedge clk) begin
		vld_q[0]  <= mem_rd;
		addr_q[0] <= addr;
		for (int s = 1; s < latency; s++) begin
			vld_q[s]  <= vld_q[s-1];	// shift towards the output
			addr_q[s] <= addr_q[s-1];
		end
		if (wrt_mem) begin
			mem[addr] <= wdata;	// lands on the same edge as the cache write
		end
	end

	assign rvalid = vld_q[latency-1];
	assign rdata  = rvalid ? mem[addr_q[latency-1]] : '0;	// read at return time

endmodule

`default_nettype wire

// ==== tests/cache_asserts.sv ====
`default_nettype none

// protocol checks on the cache boundary
module cache_asserts (
	input logic clk,
	input logic rst,
	input logic wrt_cmd,
	input logic hit,
	input logic fsm_busy,
	input logic mem_rd,
	input logic wrt_mem
);

	// controller comes out of reset idle
	reset_idle: assert property (@(posedge clk) rst |=> !fsm_busy)
		else $error("fsm_busy high in the cycle after reset");

	// write-through only for a write hit while idle
	write_through_hit: assert property (@(posedge clk) disable iff (rst)
		wrt_mem |-> (wrt_cmd && hit && !fsm_busy))
		else $error("wrt_mem without a write hit or while busy");

	fill_read_busy: assert property (@(posedge clk) disable iff (rst)
		mem_rd |-> fsm_busy)	// reads belong to a fill
		else $error("mem_rd while fsm_busy is low");

endmodule

`default_nettype wire

// ==== tests/cache_tb.sv ====
`default_nettype none

// requester drives on the falling edge and the checks sample on the rising edge
module cache_tb import cache_pkg::*; ();

	localparam int mem_latency    = 4;
	localparam int miss_cycles    = mem_latency + words_per_block + 2;	// request to completion
	localparam int num_ops        = 67;	// accesses over all behaviors
	localparam int timeout_cycles = 2 * num_ops * (miss_cycles + 1);	// room for every op to miss twice

	logic              clk;
	logic              rst;
	logic              read_req;
	logic              wrt_cmd;
	cache_addr_t       addr_in;
	logic [data_w-1:0] wr_data;	// requester side of the shared bus
	logic [data_w-1:0] mem_data;
	logic [data_w-1:0] mem_rdata;	// memory side of the shared bus
	logic              mem_data_valid;
	logic              hit;
	logic              fsm_busy;
	logic              mem_rd;
	logic              wrt_mem;
	cache_addr_t       miss_addr;
	logic [data_w-1:0] data_out;

	logic [data_w-1:0] shadow [logic [15:0]];	// words written so far by byte address
	int seed       = 32551;
	int done_cnt   = 0;	// completions seen by the compare process
	int checks     = 0;
	int mismatches = 0;
	int failures   = 0;
	int cycle_cnt  = 0;

	assign mem_data = mem_data_valid ? mem_rdata : wr_data;	// returned fill words win the bus

	tb_clock clk_i (
		.clk (clk)
	);

	mem_model #(.latency(mem_latency)) mem_i (
		.clk    (clk),
		.mem_rd (mem_rd),
		.wrt_mem(wrt_mem),
		.addr   (miss_addr),
		.wdata  (mem_data),
		.rdata  (mem_rdata),
		.rvalid (mem_data_valid)
	);

	cache dut_i (
		.clk            (clk),
		.rst            (rst),
		.read_req       (read_req),
		.wrt_cmd        (wrt_cmd),
		.addr_in        (addr_in),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid),
		.hit            (hit),
		.fsm_busy       (fsm_busy),
		.mem_rd         (mem_rd),
		.wrt_mem        (wrt_mem),
		.miss_addr      (miss_addr),
		.data_out       (data_out)
	);

	bind cache cache_asserts asserts_i (
		.clk      (clk),
		.rst      (rst),
		.wrt_cmd  (wrt_cmd),
		.hit      (hit),
		.fsm_busy (fsm_busy),
		.mem_rd   (mem_rd),
		.wrt_mem  (wrt_mem)
	);

	// same pattern the memory is loaded with
	function automatic logic [data_w-1:0] preload_word(input logic [15:0] a);
		return (a ^ 16'h3c5a) + {a[7:0], a[15:8]};
	endfunction

	// reference gives the last written value or else the preload pattern
	function automatic logic [data_w-1:0] expected_word(input logic [15:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return preload_word(a);
	endfunction

	function automatic cache_addr_t make_addr(input int tag, input int index, input int offset);
		cache_addr_t a;
		a.tag    = tag_w'(tag);
		a.index  = index_w'(index);
		a.offset = offset_w'(offset);
		a.zero   = 1'b0;	// word aligned
		return a;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		failures++;
	endtask

	// compare on every completion cycle
	always @(posedge clk) begin
		logic [15:0] key;
		if (!rst && (read_req || wrt_cmd) && hit && !fsm_busy) begin
			key = addr_in;
			checks++;
			if (wrt_cmd) begin
				assert (wrt_mem === 1'b1)
					else report_mismatch("wrt_mem", 16'(wrt_mem), 16'd1);
				assert (miss_addr === addr_in)
					else report_mismatch("miss_addr", miss_addr, addr_in);
				shadow[key] = wr_data;	// memory now holds it too
			end else begin
				assert (data_out === expected_word(key))
					else report_mismatch("data_out", data_out, expected_word(key));
			end
			done_cnt++;
		end
	end

	// hold one command until the compare process sees it complete
	task automatic access(input logic is_wr, input cache_addr_t a, input logic [data_w-1:0] d,
			output int lat, output bit busy_seen);
		int start;
		start     = done_cnt;
		read_req  = !is_wr;
		wrt_cmd   = is_wr;
		addr_in   = a;
		wr_data   = d;
		lat       = 0;	// extra cycles beyond the first
		busy_seen = 1'b0;
		@(negedge clk);
		while (done_cnt == start) begin
			lat++;
			busy_seen |= fsm_busy;
			@(negedge clk);
		end
		read_req = 1'b0;
		wrt_cmd  = 1'b0;
	endtask

	// want < 0 leaves the latency unchecked
	task automatic check_latency(input cache_addr_t a, input int lat, input bit busy_seen,
			input int want);
		if (want >= 0) begin
			assert (lat == want)
				else report_failure($sformatf("access to %h took %0d extra cycles, not %0d",
					a, lat, want));
		end
		if (want > 0) begin
			assert (busy_seen)
				else report_failure($sformatf("miss on %h never raised fsm_busy", a));
		end
	endtask

	task automatic read_at(input cache_addr_t a, input int want);
		int lat;
		bit busy_seen;
		access(1'b0, a, '0, lat, busy_seen);
		check_latency(a, lat, busy_seen, want);
	endtask

	task automatic write_at(input cache_addr_t a, input logic [data_w-1:0] d, input int want);
		int lat;
		bit busy_seen;
		access(1'b1, a, d, lat, busy_seen);
		check_latency(a, lat, busy_seen, want);
	endtask

	task automatic finish_run(input bit timed_out);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (!timed_out && mismatches == 0 && failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	// run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles) begin
			report_failure("timeout, a request never completed");
			finish_run(1'b1);
		end
	end

	initial begin
		cache_addr_t       a;
		cache_addr_t       b;
		int                r;
		logic [data_w-1:0] d;
		rst      = 1'b1;
		read_req = 1'b0;
		wrt_cmd  = 1'b0;
		addr_in  = '0;
		wr_data  = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		read_at(make_addr(2, 5, 3), miss_cycles);	// cold miss
		read_at(make_addr(2, 5, 6), 0);	// same block hits at once
		for (int o = 0; o < words_per_block; o++) begin
			read_at(make_addr(2, 5, o), 0);	// every word of the block
		end

		// write hit goes through to memory
		a = make_addr(2, 5, 4);
		write_at(a, 16'hbeef, 0);
		read_at(a, 0);
		assert (mem_i.mem[16'(a)] === 16'hbeef)
			else report_mismatch("mem_i.mem", mem_i.mem[16'(a)], 16'hbeef);

		// write miss fills first and neighbours keep memory data
		a = make_addr(7, 90, 1);
		write_at(a, 16'h1234, miss_cycles);
		for (int o = 0; o < words_per_block; o++) begin
			read_at(make_addr(7, 90, o), 0);
		end

		// same index with different tags so each one evicts the other
		a = make_addr(3, 20, 2);
		b = make_addr(9, 20, 5);
		repeat (3) begin
			read_at(a, miss_cycles);
			read_at(b, miss_cycles);
		end

		// random mix in a window of 2 tags x 4 indexes
		for (int n = 0; n < 40; n++) begin
			r = $random(seed);
			d = 16'($random(seed));
			a = make_addr(int'(r[1]), 40 + int'(r[3:2]), int'(r[6:4]));
			if (r[7]) begin
				write_at(a, d, -1);
			end else begin
				read_at(a, -1);
			end
		end

		finish_run(1'b0);
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/cache_pkg.sv
rtl/data_array.sv
rtl/meta_data_array.sv
rtl/cache_fill_fsm.sv
rtl/cache.sv
tests/tb_clock.sv
tests/mem_model.sv
tests/cache_asserts.sv
tests/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cache_tb \
	-f verilog.f \
	-o cache_sim

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0
